// File: build.f
+incdir+.
mem_bus_pkg.sv
bus_sequencer.sv
write_lane_aligner.sv
read_lane_merger.sv
bus_watchdog.sv
bus_bridge_top.sv
bus_bridge_asserts.sv
bus_bridge_tb.sv

// File: bus_bridge_asserts.sv
`timescale 1ns/100ps
`default_nettype none

module bus_bridge_asserts
    import mem_bus_pkg::*;
(
    input wire         clock,
    input wire         reset,
    input aw_channel_t aw,
    input wire         awready,
    input w_channel_t  w,
    input wire         wready,
    input ar_channel_t ar,
    input wire         arready,
    input wire         bready,
    input wire         rready,
    input wire         execute,
    input wire         core_done,
    input wire         bus_timeout
);

    int violations = 0;

    aw_hold: assert property (@(posedge clock) disable iff (reset)
        aw.valid && !awready |=> aw.valid && $stable(aw.addr))
        else begin violations++; $error("aw valid or address changed before its handshake"); end

    w_hold: assert property (@(posedge clock) disable iff (reset)
        w.valid && !wready |=> w.valid && $stable(w.data) && $stable(w.strb))
        else begin violations++; $error("w valid or payload changed before its handshake"); end

    ar_hold: assert property (@(posedge clock) disable iff (reset)
        ar.valid && !arready |=> ar.valid && $stable(ar.addr))
        else begin violations++; $error("ar valid or address changed before its handshake"); end

    // One transaction at a time, so both address channels never compete.
    aw_ar_exclusive: assert property (@(posedge clock) disable iff (reset)
        !(aw.valid && ar.valid))
        else begin violations++; $error("aw and ar valid are high together"); end

    quiet_after_reset: assert property (@(posedge clock)
        reset |=> !aw.valid && !w.valid && !ar.valid && !bready && !rready
                  && !execute && !core_done && !bus_timeout)
        else begin violations++; $error("an output is not low after reset"); end

    timeout_sticky: assert property (@(posedge clock) disable iff (reset)
        bus_timeout |=> bus_timeout)
        else begin violations++; $error("bus_timeout fell without a reset"); end

endmodule

bind bus_bridge_top bus_bridge_asserts i_bus_bridge_asserts (.*);

`default_nettype wire

// File: bus_bridge_tb.sv
`timescale 1ns/100ps
`default_nettype none

module bus_bridge_tb
    import mem_bus_pkg::*;
();

    localparam int CYCLE_LIMIT = 4000;
    // Scripted store and load shapes, one offset and one mask per entry.
    localparam logic [19:0] OFFSETS = {2'd0, 2'd0, 2'd0, 2'd1, 2'd2, 2'd3, 2'd3, 2'd1, 2'd2, 2'd3};
    localparam logic [39:0] MASKS = {4'hf, 4'h3, 4'h1, 4'hf, 4'hf, 4'hf, 4'h3, 4'h1, 4'h3, 4'h1};

    logic clock, reset, execute, core_done, bus_timeout;
    logic awready, wready, bvalid, bready, arready, rvalid, rready;
    bus_addr_t pc;
    lsu_request_t request;
    bus_data_t instruction, load_data, rdata;
    aw_channel_t aw;
    w_channel_t w;
    ar_channel_t ar;

    logic [7:0] mem [0:1023];
    logic [7:0] exp_mem [0:1023];
    // Bus delays and core stimulus each step their own LFSR state.
    logic [31:0] delay_lfsr = 32'h2d9f_e92d;
    logic [31:0] stim_lfsr = 32'h2d9f_e92d;
    int errors = 0;
    int cycles = 0;
    int delay, beats_seen, wr_beat, stall_cycles;
    logic hold_ar, ar_go, r_go, aw_go, w_go, b_go;
    bus_addr_t ar_q, aw_q, read_addr, write_addr;
    w_channel_t w_q;
    bus_addr_t exp_addr [2];
    bus_strb_t exp_strb [2];
    bus_data_t exp_data [2];

    bus_bridge_top i_bus_bridge_top (.*);

    always #20 clock = ~clock;

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    function automatic logic [31:0] take_bits(input int n, inout logic [31:0] state);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], state[0]};
            state = lfsr_step(state);
        end
        return v;
    endfunction

    function automatic bus_data_t lane_bits(input bus_strb_t strb);
        return {{8{strb[3]}}, {8{strb[2]}}, {8{strb[1]}}, {8{strb[0]}}};
    endfunction

    function automatic bus_data_t word_of(input bus_addr_t addr, input logic use_expected);
        int i;
        i = int'({addr[9:2], 2'b00});
        if (use_expected) return {exp_mem[i+3], exp_mem[i+2], exp_mem[i+1], exp_mem[i]};
        return {mem[i+3], mem[i+2], mem[i+1], mem[i]};
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        assert (got == expected) else begin
            errors++;
            $display("mismatch at %0t: %s got %h expected %h", $time, name, got, expected);
        end
    endtask

    task automatic check_true(input logic cond, input string what);
        assert (cond) else begin
            errors++;
            $display("error at %0t: %s", $time, what);
        end
    endtask

    task automatic store_beat();
        int i;
        i = int'({write_addr[9:2], 2'b00});
        if (wr_beat < 2) begin
            check_value("awaddr", write_addr, exp_addr[wr_beat]);
            check_value("wstrb", 32'(w_q.strb), 32'(exp_strb[wr_beat]));
            check_value("wdata", w_q.data & lane_bits(w_q.strb),
                        exp_data[wr_beat] & lane_bits(exp_strb[wr_beat]));
        end else begin
            check_true(1'b0, "more than two write beats for one store");
        end
        for (int k = 0; k < 4; k++) begin
            if (w_q.strb[k]) mem[i+k] = w_q.data[8*k +: 8];
        end
        wr_beat++;
    endtask

    // Slave memory model; each handshake completes on the edge after both sides were high.
    always @(negedge clock) begin
        if (reset) begin
            {awready, wready, bvalid, arready, rvalid} = '0;
            rdata = '0;
            delay = 0;
        end else begin
            if (ar_go) begin
                arready = 1'b0;
                read_addr = ar_q;
                delay = take_bits(2, delay_lfsr);
            end
            if (r_go) begin
                rvalid = 1'b0;
                delay = take_bits(2, delay_lfsr);
            end
            if (aw_go) begin
                awready = 1'b0;
                write_addr = aw_q;
                beats_seen++;
                delay = take_bits(2, delay_lfsr);
            end
            if (w_go) begin
                wready = 1'b0;
                store_beat();
                delay = take_bits(2, delay_lfsr);
            end
            if (b_go) begin
                bvalid = 1'b0;
                delay = take_bits(2, delay_lfsr);
            end
            if (delay != 0) begin
                delay--;
            end else if (ar.valid && !arready) begin
                if (!hold_ar) arready = 1'b1;
            end else if (rready && !rvalid) begin
                rvalid = 1'b1;
                rdata = word_of(read_addr, 1'b0);
            end else if (aw.valid && !awready) begin
                awready = 1'b1;
            end else if (w.valid && !wready) begin
                wready = 1'b1;
            end else if (bready && !bvalid) begin
                bvalid = 1'b1;
            end
            if (!hold_ar) check_true(!bus_timeout, "bus_timeout rose under normal delays");
        end
        ar_go = ar.valid && arready;
        r_go = rready && rvalid;
        aw_go = aw.valid && awready;
        w_go = w.valid && wready;
        b_go = bready && bvalid;
        ar_q = ar.addr;
        aw_q = aw.addr;
        w_q = w;
    end

    task automatic run_step(input logic st, input logic ld, input logic [1:0] off,
                            input bus_strb_t mask, input logic [7:0] word_index);
        bus_addr_t addr;
        bus_data_t data, expected;
        int n, lane;
        logic split;
        addr = {22'd0, word_index, off};
        data = take_bits(32, stim_lfsr);
        n = mask == 4'hf ? 4 : (mask == 4'h3 ? 2 : 1);
        split = (off + n) > 4;
        do @(negedge clock); while (!execute);
        check_value("instruction", instruction, word_of(pc, 1'b1));
        expected = '0;
        for (int k = 0; k < 4; k++) begin
            if (split || off + k < 4) expected[8*k +: 8] = exp_mem[(addr[9:0] + k) % 1024];
        end
        exp_addr[0] = {addr[31:2], 2'b00};
        exp_addr[1] = exp_addr[0] + 4;
        exp_strb = '{default: '0};
        exp_data = '{default: '0};
        for (int k = 0; k < n && st; k++) begin
            lane = off + k;
            exp_strb[lane / 4][lane % 4] = 1'b1;
            exp_data[lane / 4][8*(lane % 4) +: 8] = data[8*k +: 8];
            exp_mem[(addr[9:0] + k) % 1024] = data[8*k +: 8];
        end
        beats_seen = 0;
        wr_beat = 0;
        pc = take_bits(10, stim_lfsr);
        request = '{store: st, load: ld, address: addr, data: data, mask: mask};
        do @(negedge clock); while (!core_done);
        request = '0;
        check_value("aw beats", beats_seen, !st ? 0 : (split ? 2 : 1));
        if (ld && !st) check_value("load_data", load_data, expected);
    endtask

    initial begin
        logic [7:0] word_index;
        clock = 1'b0;
        reset = 1'b1;
        pc = 32'h0000_0010;
        request = '0;
        hold_ar = 1'b0;
        {awready, wready, bvalid, arready, rvalid} = '0;
        rdata = '0;
        for (int i = 0; i < 1024; i++) begin
            mem[i] = 8'((i * 13) ^ (i >> 5) ^ 8'h96);
            exp_mem[i] = mem[i];
        end
        repeat (10) @(negedge clock);
        reset = 1'b0;
        for (int s = 0; s < 10; s++) begin
            word_index = 8'(take_bits(8, stim_lfsr));
            run_step(1'b1, 1'b0, OFFSETS[2*s +: 2], MASKS[4*s +: 4], word_index);
            run_step(1'b0, 1'b1, OFFSETS[2*s +: 2], MASKS[4*s +: 4], word_index);
            run_step(1'b0, 1'b0, 2'd0, 4'h0, 8'd0);
        end
        for (int i = 0; i < 1024; i++) begin
            check_value("memory byte", 32'(mem[i]), 32'(exp_mem[i]));
        end
        // The next fetch address is never accepted, so the watchdog must fire.
        do @(negedge clock); while (!execute);
        hold_ar = 1'b1;
        stall_cycles = 0;
        while (!bus_timeout && stall_cycles < 100) begin
            @(negedge clock);
            stall_cycles++;
        end
        check_true(bus_timeout, "bus_timeout did not rise while arready was withheld");
        check_true(stall_cycles >= 64, "bus_timeout rose before 64 stalled cycles");
        repeat (10) @(negedge clock);
        check_true(bus_timeout, "bus_timeout fell without a reset");
        $display("errors: %0d, assertion failures: %0d", errors,
                 i_bus_bridge_top.i_bus_bridge_asserts.violations);
        if (errors == 0 && i_bus_bridge_top.i_bus_bridge_asserts.violations == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

    always @(posedge clock) begin
        cycles++;
        if (cycles >= CYCLE_LIMIT) begin
            $display("run stopped after %0d cycles without finishing the tests", cycles);
            $display("errors: %0d", errors);
            $display("TEST FAIL");
            $finish;
        end
    end

endmodule

`default_nettype wire

// File: bus_bridge_top.sv
`timescale 1ns/100ps
`default_nettype none

module bus_bridge_top
    import mem_bus_pkg::*;
(
    input  wire          clock,
    input  wire          reset,
    input  bus_addr_t    pc,
    input  lsu_request_t request,
    output wire          execute,
    output bus_data_t    instruction,
    output bus_data_t    load_data,
    output wire          core_done,
    output wire          bus_timeout,
    output aw_channel_t  aw,
    input  wire          awready,
    output wire w_channel_t w,
    input  wire          wready,
    input  wire          bvalid,
    output wire          bready,
    output ar_channel_t  ar,
    input  wire          arready,
    input  wire          rvalid,
    input  bus_data_t    rdata,
    output wire          rready
);

    wire          w_valid;
    bus_data_t    w_data;
    bus_strb_t    w_strb;
    write_phase_t write_phase;
    read_phase_t  read_phase;
    lsu_request_t held_request;
    wire          stalled;

    assign w = {w_valid, w_data, w_strb};

    bus_sequencer i_bus_sequencer (
        .clock        (clock),
        .reset        (reset),
        .pc           (pc),
        .request      (request),
        .awready      (awready),
        .wready       (wready),
        .bvalid       (bvalid),
        .arready      (arready),
        .rvalid       (rvalid),
        .aw           (aw),
        .ar           (ar),
        .w_valid      (w_valid),
        .bready       (bready),
        .rready       (rready),
        .write_phase  (write_phase),
        .read_phase   (read_phase),
        .held_request (held_request),
        .execute      (execute),
        .core_done    (core_done),
        .stalled      (stalled)
    );

    write_lane_aligner i_write_lane_aligner (
        .held_request (held_request),
        .write_phase  (write_phase),
        .data         (w_data),
        .strb         (w_strb)
    );

    read_lane_merger i_read_lane_merger (
        .clock       (clock),
        .reset       (reset),
        .read_phase  (read_phase),
        .rvalid      (rvalid),
        .rdata       (rdata),
        .offset      (held_request.address[1:0]),
        .instruction (instruction),
        .load_data   (load_data)
    );

    bus_watchdog i_bus_watchdog (
        .clock       (clock),
        .reset       (reset),
        .stalled     (stalled),
        .bus_timeout (bus_timeout)
    );

endmodule

`default_nettype wire

// File: bus_sequencer.sv
`timescale 1ns/100ps
`default_nettype none

`include "mem_bus_macros.svh"

module bus_sequencer
    import mem_bus_pkg::*;
(
    input  wire          clock,
    input  wire          reset,
    input  bus_addr_t    pc,
    input  lsu_request_t request,
    input  wire          awready,
    input  wire          wready,
    input  wire          bvalid,
    input  wire          arready,
    input  wire          rvalid,
    output aw_channel_t  aw,
    output ar_channel_t  ar,
    output logic         w_valid,
    output logic         bready,
    output logic         rready,
    output write_phase_t write_phase,
    output read_phase_t  read_phase,
    output lsu_request_t held_request,
    output logic         execute,
    output logic         core_done,
    output logic         stalled
);

    seq_state_t state;
    seq_state_t next_state;
    logic       split;
    logic       high_beat;
    bus_addr_t  word_addr;
    bus_addr_t  beat_addr;
    bus_addr_t  fetch_addr;
    logic       aw_fire;
    logic       w_fire;
    logic       b_fire;
    logic       ar_fire;
    logic       r_fire;

    assign aw_fire = aw.valid & awready;
    assign w_fire  = w_valid & wready;
    assign b_fire  = bready & bvalid;
    assign ar_fire = ar.valid & arready;
    assign r_fire  = rready & rvalid;

    always_comb begin
        next_state = state;
        case (state)
            IDLE:       next_state = FETCH_ADDR;
            FETCH_ADDR: if (ar_fire) next_state = FETCH_DATA;
            FETCH_DATA: if (r_fire) next_state = EXECUTE;
            EXECUTE: begin
                if (request.store) next_state = STORE_ADDR;
                else if (request.load) next_state = LOAD_ADDR;
                else next_state = FETCH_ADDR;
            end
            STORE_ADDR: if (aw_fire) next_state = STORE_DATA;
            STORE_DATA: if (w_fire) next_state = STORE_RESP;
            STORE_RESP: begin
                if (b_fire) next_state = (split && !high_beat) ? STORE_ADDR : FETCH_ADDR;
            end
            LOAD_ADDR:  if (ar_fire) next_state = LOAD_DATA;
            LOAD_DATA: begin
                if (r_fire) next_state = (split && !high_beat) ? LOAD_ADDR : FETCH_ADDR;
            end
            default:    next_state = IDLE;
        endcase
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            state     <= IDLE;
            split     <= 1'b0;
            high_beat <= 1'b0;
            core_done <= 1'b0;
        end else begin
            state     <= next_state;
            core_done <= (next_state == FETCH_ADDR) && (state != FETCH_ADDR) && (state != IDLE);
            if (state == EXECUTE) begin
                split     <= lane_needs_split(request.address[1:0], request.mask);
                high_beat <= 1'b0;
            end else if ((b_fire || (r_fire && state == LOAD_DATA)) && split) begin
                // Low beat finished; the next address phase is the high word.
                high_beat <= 1'b1;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (state == EXECUTE) begin
            held_request <= request;
        end
    end

    assign word_addr  = {held_request.address[`BUS_ADDR_BITS-1:2], 2'b00};
    assign beat_addr  = high_beat ? word_addr + bus_addr_t'(4) : word_addr;
    assign fetch_addr = {pc[`BUS_ADDR_BITS-1:2], 2'b00};

    assign aw = '{valid: state == STORE_ADDR, addr: beat_addr};
    assign ar = '{valid: (state == FETCH_ADDR) || (state == LOAD_ADDR),
                  addr:  (state == FETCH_ADDR) ? fetch_addr : beat_addr};

    assign w_valid = state == STORE_DATA;
    assign bready  = state == STORE_RESP;
    assign rready  = (state == FETCH_DATA) || (state == LOAD_DATA);
    assign execute = state == EXECUTE;

    always_comb begin
        write_phase = WR_NONE;
        if (state == STORE_DATA) write_phase = high_beat ? WR_HIGH : WR_LOW;
    end

    always_comb begin
        read_phase = RD_NONE;
        if (state == FETCH_DATA) begin
            read_phase = RD_FETCH;
        end else if (state == LOAD_DATA) begin
            if (!split) read_phase = RD_LOAD_ONLY;
            else read_phase = high_beat ? RD_LOAD_HIGH : RD_LOAD_LOW;
        end
    end

    assign stalled = (aw.valid & !awready) | (w_valid & !wready) | (bready & !bvalid)
                   | (ar.valid & !arready) | (rready & !rvalid);

endmodule

`default_nettype wire

// File: bus_watchdog.sv
`timescale 1ns/100ps
`default_nettype none

`include "mem_bus_macros.svh"

module bus_watchdog
    import mem_bus_pkg::*;
(
    input  wire  clock,
    input  wire  reset,
    input  wire  stalled,
    output logic bus_timeout
);

    localparam watchdog_count_t LIMIT = watchdog_count_t'(`BUS_TIMEOUT_CYCLES);

    watchdog_count_t count;

    always_ff @(posedge clock) begin
        if (reset) begin
            count       <= '0;
            bus_timeout <= 1'b0;
        end else begin
            if (!stalled) count <= '0;
            else if (count != LIMIT) count <= count + watchdog_count_t'(1);
            // Sticky until the next reset.
            if (count == LIMIT) bus_timeout <= 1'b1;
        end
    end

endmodule

`default_nettype wire

// File: mem_bus_macros.svh
`ifndef MEM_BUS_MACROS_SVH
`define MEM_BUS_MACROS_SVH

// Bus widths of the single-beat master port.
`define BUS_ADDR_BITS 32
`define BUS_DATA_BITS 32
`define BUS_STRB_BITS 4

// Consecutive stalled handshake cycles before the watchdog fires.
`define BUS_TIMEOUT_CYCLES 64

`endif

// File: mem_bus_pkg.sv
`default_nettype none

`include "mem_bus_macros.svh"

package mem_bus_pkg;

    typedef logic [`BUS_ADDR_BITS-1:0] bus_addr_t;
    typedef logic [`BUS_DATA_BITS-1:0] bus_data_t;
    typedef logic [`BUS_STRB_BITS-1:0] bus_strb_t;
    typedef logic [1:0]                lane_offset_t;

    // Wide enough to hold the timeout limit itself.
    typedef logic [$clog2(`BUS_TIMEOUT_CYCLES + 1)-1:0] watchdog_count_t;

    typedef struct packed {
        logic      store;
        logic      load;
        bus_addr_t address;
        bus_data_t data;
        bus_strb_t mask;
    } lsu_request_t;

    typedef enum logic [1:0] {
        WR_NONE,
        WR_LOW,
        WR_HIGH
    } write_phase_t;

    typedef enum logic [2:0] {
        RD_NONE,
        RD_FETCH,
        RD_LOAD_ONLY,
        RD_LOAD_LOW,
        RD_LOAD_HIGH
    } read_phase_t;

    typedef enum logic [3:0] {
        IDLE,
        FETCH_ADDR,
        FETCH_DATA,
        EXECUTE,
        STORE_ADDR,
        STORE_DATA,
        STORE_RESP,
        LOAD_ADDR,
        LOAD_DATA
    } seq_state_t;

    typedef struct packed {
        logic      valid;
        bus_addr_t addr;
    } aw_channel_t;

    typedef struct packed {
        logic      valid;
        bus_data_t data;
        bus_strb_t strb;
    } w_channel_t;

    typedef struct packed {
        logic      valid;
        bus_addr_t addr;
    } ar_channel_t;

    // Only 0001, 0011 and 1111 are legal masks.
    function automatic logic lane_needs_split(input lane_offset_t offset, input bus_strb_t mask);
        logic [2:0] count;
        case (mask)
            4'b0001: count = 3'd1;
            4'b0011: count = 3'd2;
            default: count = 3'd4;
        endcase
        return ({1'b0, offset} + count) > 3'd4;
    endfunction

endpackage

`default_nettype wire

// File: read_lane_merger.sv
`timescale 1ns/100ps
`default_nettype none

module read_lane_merger
    import mem_bus_pkg::*;
(
    input  wire          clock,
    input  wire          reset,
    input  read_phase_t  read_phase,
    input  wire          rvalid,
    input  bus_data_t    rdata,
    input  lane_offset_t offset,
    output bus_data_t    instruction,
    output bus_data_t    load_data
);

    bus_data_t hold;
    bus_data_t merged;

    // Low beat bytes from the offset up, then the start of the high beat above them.
    always_comb begin
        case (offset)
            2'd1:    merged = {rdata[7:0], hold[31:8]};
            2'd2:    merged = {rdata[15:0], hold[31:16]};
            2'd3:    merged = {rdata[23:0], hold[31:24]};
            default: merged = rdata;
        endcase
    end

    always_ff @(posedge clock) begin
        if (rvalid && read_phase == RD_LOAD_LOW) begin
            hold <= rdata;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            instruction <= '0;
            load_data   <= '0;
        end else if (rvalid) begin
            case (read_phase)
                RD_FETCH:     instruction <= rdata;
                RD_LOAD_ONLY: load_data <= rdata >> {offset, 3'b000};
                RD_LOAD_HIGH: load_data <= merged;
                default:      ;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f build.f --top-module bus_bridge_tb -o bus_bridge_sim
output=$(./obj_dir/bus_bridge_sim)
echo "$output"
echo "$output" | grep -qx "TEST PASS"

// File: write_lane_aligner.sv
`timescale 1ns/100ps
`default_nettype none

`include "mem_bus_macros.svh"

module write_lane_aligner
    import mem_bus_pkg::*;
(
    input  lsu_request_t held_request,
    input  write_phase_t write_phase,
    output bus_data_t    data,
    output bus_strb_t    strb
);

    lane_offset_t                     offset;
    logic [2*`BUS_DATA_BITS-1:0]      data_wide;
    logic [2*`BUS_STRB_BITS-1:0]      strb_wide;

    assign offset = held_request.address[1:0];

    // Shift across two words at once; the upper word holds the spill for the high beat.
    assign data_wide = {{`BUS_DATA_BITS{1'b0}}, held_request.data} << {offset, 3'b000};
    assign strb_wide = {{`BUS_STRB_BITS{1'b0}}, held_request.mask} << offset;

    always_comb begin
        case (write_phase)
            WR_LOW: begin
                data = data_wide[`BUS_DATA_BITS-1:0];
                strb = strb_wide[`BUS_STRB_BITS-1:0];
            end
            WR_HIGH: begin
                data = data_wide[2*`BUS_DATA_BITS-1:`BUS_DATA_BITS];
                strb = strb_wide[2*`BUS_STRB_BITS-1:`BUS_STRB_BITS];
            end
            default: begin
                data = '0;
                strb = '0;
            end
        endcase
    end

endmodule

`default_nettype wire
